// File: tb.f
+incdir+.
arb_req_pkg.sv
arb_grant_pkg.sv
rr_thermo_arbiter.sv
member_arbiter_bank.sv
group_select.sv
grant_merge.sv
tree_arbiter.sv
tree_arbiter_assert.sv
tb_tree_arbiter.sv

// File: Bender.yml
package:
  name: tree_arbiter

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - arb_req_pkg.sv
      - arb_grant_pkg.sv
      - rr_thermo_arbiter.sv
      - member_arbiter_bank.sv
      - group_select.sv
      - grant_merge.sv
      - tree_arbiter.sv
  - target: test
    include_dirs:
      - .
    files:
      - tree_arbiter_assert.sv
      - tb_tree_arbiter.sv

// File: tb_tree_arbiter.sv
`default_nettype none

`include "tree_arb_consts.svh"

module tb_tree_arbiter;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WIDTH       = `TREE_ARB_WIDTH;
    localparam int GROUP_NUM   = `TREE_ARB_GROUP_NUM;
    localparam int GROUP_WIDTH = `TREE_ARB_GROUP_WIDTH;
    localparam int IDX_W       = `TREE_ARB_IDX_W;

    logic                  clk;
    logic                  reset;
    arb_req_pkg::req_vec_t request;
    arb_req_pkg::req_vec_t grant;
    logic [IDX_W-1:0]      grant_index;
    logic                  any_grant;

    // model pointers hold -1 while nothing has been granted since reset
    int          member_ptr [GROUP_NUM];
    int          group_ptr;
    logic [31:0] lfsr;

    tree_arbiter dut (
        .clk         (clk),
        .reset       (reset),
        .request     (request),
        .grant       (grant),
        .grant_index (grant_index),
        .any_grant   (any_grant)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // lowest active input above ptr, else lowest active, else -1
    function automatic int rr_pick(input logic [31:0] req, input int width, input int ptr);
        for (int i = ptr + 1; i < width; i++) begin
            if (req[i]) begin
                return i;
            end
        end
        for (int i = 0; i < width; i++) begin
            if (req[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    // fibonacci taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic next_random_request(output arb_req_pkg::req_vec_t req);
        for (int b = 0; b < WIDTH; b++) begin
            lfsr   = lfsr_next(lfsr);
            req[b] = lfsr[0];
        end
    endtask

    task automatic stop_on_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error at %0d ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    // compare outputs with the model, then move the model pointers
    task automatic evaluate_cycle();
        arb_req_pkg::req_vec_t exp_grant;
        logic [IDX_W-1:0]      exp_index;
        logic [GROUP_NUM-1:0]  active;
        int                    member_pick [GROUP_NUM];
        int                    group_pick;
        int                    pick_index;
        @(negedge clk);
        exp_grant = '0;
        exp_index = '0;
        for (int g = 0; g < GROUP_NUM; g++) begin
            active[g]      = |request[g*GROUP_WIDTH +: GROUP_WIDTH];
            member_pick[g] = rr_pick(32'(request[g*GROUP_WIDTH +: GROUP_WIDTH]),
                                     GROUP_WIDTH, member_ptr[g]);
        end
        group_pick = rr_pick(32'(active), GROUP_NUM, group_ptr);
        if (group_pick >= 0) begin
            pick_index            = group_pick * GROUP_WIDTH + member_pick[group_pick];
            exp_grant[pick_index] = 1'b1;
            exp_index             = IDX_W'(pick_index);
        end
        check_value("grant", 32'(exp_grant), 32'(grant));
        check_value("grant_index", 32'(exp_index), 32'(grant_index));
        check_value("any_grant", 32'(group_pick >= 0), 32'(any_grant));
        // every group with a request moves, selected or not
        for (int g = 0; g < GROUP_NUM; g++) begin
            if (member_pick[g] >= 0) begin
                member_ptr[g] = member_pick[g];
            end
        end
        if (group_pick >= 0) begin
            group_ptr = group_pick;
        end
    endtask

    task automatic step(input arb_req_pkg::req_vec_t req);
        @(posedge clk);
        request <= req;
        evaluate_cycle();
    endtask

    task automatic apply_reset(input arb_req_pkg::req_vec_t init_req);
        @(posedge clk);
        reset   <= 1'b1;
        request <= init_req;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        for (int g = 0; g < GROUP_NUM; g++) begin
            member_ptr[g] = -1;
        end
        group_ptr = -1;
        evaluate_cycle();
    endtask

    task automatic wait_for_grant(input int idx, input arb_req_pkg::req_vec_t req,
                                  input int limit);
        int cycles;
        cycles = 0;
        step(req);
        while (!(any_grant && int'(grant_index) == idx)) begin
            if (cycles == limit) begin
                $display("Timeout: requester %0d was not granted within %0d cycles",
                         idx, limit);
                stop_on_failure();
            end else begin
                cycles++;
                step(req);
            end
        end
    endtask

    task automatic test_idle();
        apply_reset('0);
        repeat (3) step('0);
        check_value("grant", 0, 32'(grant));
        check_value("grant_index", 0, 32'(grant_index));
        check_value("any_grant", 0, 32'(any_grant));
    endtask

    task automatic test_reset_and_single();
        arb_req_pkg::req_vec_t lone;
        apply_reset('1);
        // bit 0 wins straight out of reset
        check_value("grant", 1, 32'(grant));
        check_value("grant_index", 0, 32'(grant_index));
        for (int r = 0; r < WIDTH; r++) begin
            lone    = '0;
            lone[r] = 1'b1;
            step(lone);
            check_value("grant_index", r, 32'(grant_index));
            check_value("grant", 32'(lone), 32'(grant));
        end
    endtask

    task automatic test_full_rotation();
        logic [GROUP_NUM-1:0] served;
        int                   g;
        served = '0;
        for (int c = 0; c < WIDTH; c++) begin
            step('1);
            g = int'(grant_index) / GROUP_WIDTH;
            // each group once per round of four
            check_value("group served twice in one round", 0, 32'(served[g]));
            served[g] = 1'b1;
            if (&served) begin
                served = '0;
            end
        end
    endtask

    task automatic test_unselected_rotation();
        apply_reset('0);
        step(16'h00f3);
        check_value("grant_index", 0, 32'(grant_index));
        // group 1 wins while group 0 still moves on to member 1
        step(16'h00f3);
        check_value("grant_index", 5, 32'(grant_index));
        // group 0 alone now and its pointer sits at member 1 so it wraps to 0
        step(16'h0003);
        check_value("grant_index", 0, 32'(grant_index));
        wait_for_grant(1, 16'h0003, 4);
    endtask

    task automatic test_random();
        arb_req_pkg::req_vec_t req;
        for (int c = 0; c < 300; c++) begin
            next_random_request(req);
            step(req);
        end
    endtask

    initial begin
        reset   = 1'b1;
        request = '0;
        lfsr    = 32'h6640_b1ec;
        test_idle();
        test_reset_and_single();
        test_full_rotation();
        test_unselected_rotation();
        test_random();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tree_arbiter_assert.sv
`default_nettype none

`include "tree_arb_consts.svh"

module tree_arbiter_assert (
    input wire logic                       clk,
    input wire logic                       reset,
    input wire arb_req_pkg::req_vec_t      request,
    input wire arb_req_pkg::req_vec_t      grant,
    input wire logic [`TREE_ARB_IDX_W-1:0] grant_index,
    input wire logic                       any_grant
);

    timeunit 1ns;
    timeprecision 1ps;

    a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(grant))
        else $error("grant has more than one bit set");

    // a grant only goes to an asking input
    a_grant_has_request: assert property (@(posedge clk) disable iff (reset)
        (grant & ~request) == '0)
        else $error("grant bit set without its request");

    a_any_grant: assert property (@(posedge clk) disable iff (reset)
        any_grant == |request)
        else $error("any_grant differs from OR of requests");

    a_index_matches: assert property (@(posedge clk) disable iff (reset)
        any_grant |-> grant[grant_index])
        else $error("grant_index does not point at the granted bit");

endmodule

bind tree_arbiter tree_arbiter_assert u_assert (
    .clk         (clk),
    .reset       (reset),
    .request     (request),
    .grant       (grant),
    .grant_index (grant_index),
    .any_grant   (any_grant)
);

`default_nettype wire

// File: tree_arbiter.sv
`default_nettype none

`include "tree_arb_consts.svh"

module tree_arbiter (
    input  logic                       clk,
    input  logic                       reset,
    input  arb_req_pkg::req_vec_t      request,
    output arb_req_pkg::req_vec_t      grant,
    output logic [`TREE_ARB_IDX_W-1:0] grant_index,
    output logic                       any_grant
);

    arb_grant_pkg::member_grants_t member_grants;
    arb_grant_pkg::group_choice_t  choice;
    arb_grant_pkg::tree_grant_t    result;

    // first level, one pick per group
    member_arbiter_bank u_bank (
        .clk           (clk),
        .reset         (reset),
        .request       (request),
        .member_grants (member_grants)
    );

    // second level, in parallel with the first
    group_select u_group_sel (
        .clk     (clk),
        .reset   (reset),
        .request (request),
        .choice  (choice)
    );

    grant_merge u_merge (
        .member_grants (member_grants),
        .choice        (choice),
        .result        (result)
    );

    assign grant       = result.grant;
    assign grant_index = result.index;
    assign any_grant   = result.valid;

endmodule

`default_nettype wire

// File: grant_merge.sv
`default_nettype none

`include "tree_arb_consts.svh"

module grant_merge (
    input  arb_grant_pkg::member_grants_t member_grants,
    input  arb_grant_pkg::group_choice_t  choice,
    output arb_grant_pkg::tree_grant_t    result
);

    localparam int GROUP_NUM    = `TREE_ARB_GROUP_NUM;
    localparam int GROUP_IDX_W  = `TREE_ARB_GROUP_IDX_W;
    localparam int MEMBER_IDX_W = `TREE_ARB_IDX_W - `TREE_ARB_GROUP_IDX_W;

    arb_grant_pkg::member_grants_t masked;
    arb_req_pkg::group_vec_t       sel_member;
    logic [GROUP_IDX_W-1:0]        group_idx;
    logic [MEMBER_IDX_W-1:0]       member_idx;

    // only the chosen group keeps its member grant
    for (genvar g = 0; g < GROUP_NUM; g++) begin : g_mask
        assign masked[g] = choice.sel[g] ? member_grants[g] : '0;
    end

    // at most one group survives, so the OR is that group's member grant
    always_comb begin
        sel_member = '0;
        for (int g = 0; g < GROUP_NUM; g++) begin
            sel_member = sel_member | masked[g];
        end
    end

    // one-hot to binary, ORing the indices of set bits
    always_comb begin
        group_idx  = '0;
        member_idx = '0;
        for (int g = 0; g < GROUP_NUM; g++) begin
            if (choice.sel[g]) begin
                group_idx = group_idx | GROUP_IDX_W'(g);
            end
        end
        for (int m = 0; m < `TREE_ARB_GROUP_WIDTH; m++) begin
            if (sel_member[m]) begin
                member_idx = member_idx | MEMBER_IDX_W'(m);
            end
        end
    end

    // groups side by side give the flat grant, group 3 on top
    assign result = '{
        valid: choice.valid,
        index: {group_idx, member_idx},
        grant: masked
    };

endmodule

`default_nettype wire

// File: group_select.sv
`default_nettype none

`include "tree_arb_consts.svh"

module group_select (
    input  logic                         clk,
    input  logic                         reset,
    input  arb_req_pkg::req_vec_t        request,
    output arb_grant_pkg::group_choice_t choice
);

    localparam int GROUP_NUM = `TREE_ARB_GROUP_NUM;

    arb_req_pkg::grouped_req_t grouped;
    logic [GROUP_NUM-1:0]      group_active;
    logic [GROUP_NUM-1:0]      group_grant;
    logic                      group_valid;

    assign grouped = request;

    // a group competes when any member asks
    for (genvar g = 0; g < GROUP_NUM; g++) begin : g_active
        assign group_active[g] = |grouped[g];
    end

    // round robin among active groups
    rr_thermo_arbiter #(
        .WIDTH (GROUP_NUM)
    ) u_group_arb (
        .clk       (clk),
        .reset     (reset),
        .request   (group_active),
        .grant     (group_grant),
        .any_grant (group_valid)
    );

    assign choice = '{
        any_req: group_active,
        sel:     group_grant,
        valid:   group_valid
    };

endmodule

`default_nettype wire

// File: member_arbiter_bank.sv
`default_nettype none

`include "tree_arb_consts.svh"

module member_arbiter_bank (
    input  logic                          clk,
    input  logic                          reset,
    input  arb_req_pkg::req_vec_t         request,
    output arb_grant_pkg::member_grants_t member_grants
);

    localparam int GROUP_NUM   = `TREE_ARB_GROUP_NUM;
    localparam int GROUP_WIDTH = `TREE_ARB_GROUP_WIDTH;

    arb_req_pkg::grouped_req_t grouped;

    // flat vector split into groups of four
    assign grouped = request;

    // one arbiter per group, each moves its pointer on any request in its group
    // whether or not the group arbiter picks this group
    for (genvar g = 0; g < GROUP_NUM; g++) begin : g_member
        rr_thermo_arbiter #(
            .WIDTH (GROUP_WIDTH)
        ) u_member_arb (
            .clk       (clk),
            .reset     (reset),
            .request   (grouped[g]),
            .grant     (member_grants[g]),
            .any_grant ()
        );
    end

endmodule

`default_nettype wire

// File: rr_thermo_arbiter.sv
`default_nettype none

module rr_thermo_arbiter #(
    parameter int WIDTH = 4
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [WIDTH-1:0] request,
    output logic [WIDTH-1:0] grant,
    output logic             any_grant
);

    // ones above the last granted bit
    logic [WIDTH-1:0] prio_mask;
    logic [WIDTH-1:0] masked_req;
    logic [WIDTH-1:0] thermo_all;
    logic [WIDTH-1:0] thermo_masked;
    logic [WIDTH-1:0] thermo_sel;
    logic [WIDTH-1:0] next_mask;

    assign masked_req = request & prio_mask;

    // prefix OR from bit 0 upward, first set bit becomes the rising edge
    for (genvar i = 0; i < WIDTH; i++) begin : g_thermo
        assign thermo_all[i]    = |request[i:0];
        assign thermo_masked[i] = |masked_req[i:0];
    end

    // requests above the pointer win, else wrap to the lowest one
    assign thermo_sel = thermo_masked[WIDTH-1] ? thermo_masked : thermo_all;

    // shifted code marks everything strictly above the winner
    assign next_mask = thermo_sel << 1;

    // edge of the thermometer code is the one-hot grant
    assign grant     = thermo_sel ^ next_mask;
    assign any_grant = thermo_all[WIDTH-1];

    // all ones after reset so bit 0 wins first
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prio_mask <= '1;
        end else if (any_grant) begin
            prio_mask <= next_mask;
        end
    end

endmodule

`default_nettype wire

// File: arb_grant_pkg.sv
`default_nettype none

`include "tree_arb_consts.svh"

package arb_grant_pkg;

    // one-hot member grant of every group, pointer state not yet filtered
    typedef arb_req_pkg::group_vec_t [`TREE_ARB_GROUP_NUM-1:0] member_grants_t;

    // result of the second level
    typedef struct packed {
        // group g has at least one request
        logic [`TREE_ARB_GROUP_NUM-1:0] any_req;
        // one-hot winning group
        logic [`TREE_ARB_GROUP_NUM-1:0] sel;
        logic                           valid;
    } group_choice_t;

    // final answer of the tree
    typedef struct packed {
        logic                       valid;
        logic [`TREE_ARB_IDX_W-1:0] index;
        arb_req_pkg::req_vec_t      grant;
    } tree_grant_t;

endpackage

`default_nettype wire

// File: arb_req_pkg.sv
`default_nettype none

`include "tree_arb_consts.svh"

package arb_req_pkg;

    // bit i is requester i
    typedef logic [`TREE_ARB_WIDTH-1:0] req_vec_t;

    // one group's members, bit m is member m of the group
    typedef logic [`TREE_ARB_GROUP_WIDTH-1:0] group_vec_t;

    // element g holds requesters 4g to 4g+3
    // same bit layout as req_vec_t, so a plain assignment reshapes
    typedef group_vec_t [`TREE_ARB_GROUP_NUM-1:0] grouped_req_t;

endpackage

`default_nettype wire

// File: tree_arb_consts.svh
`ifndef TREE_ARB_CONSTS_SVH
`define TREE_ARB_CONSTS_SVH

// number of requesters at the top level
`define TREE_ARB_WIDTH 16

// groups seen by the second level arbiter
`define TREE_ARB_GROUP_NUM 4

// requesters per group, TREE_ARB_WIDTH / TREE_ARB_GROUP_NUM
`define TREE_ARB_GROUP_WIDTH 4

// bits of a group number
`define TREE_ARB_GROUP_IDX_W 2

// bits of a requester number, group bits on top of member bits
`define TREE_ARB_IDX_W 4

`endif
